// ==== rtl/cps_bus_config.svh ====
`ifndef CPS_BUS_CONFIG_SVH
`define CPS_BUS_CONFIG_SVH

//////////////////////////////
// address map, byte addresses
//////////////////////////////
`define ROM_LAST        24'h3FFFFF // program rom top
`define PLAYER_BASE     24'h800000 // 4 words of player ports
`define SERV_BASE       24'h800018 // coin / start / service
`define DIPA_BASE       24'h80001A
`define DIPB_BASE       24'h80001C
`define DIPC_BASE       24'h80001E
`define CPSA_BASE       24'h800100 // 32-word window
`define CPSB_BASE       24'h800140 // 32-word window
`define RAM_BASE        24'hFF0000 // 64KB up to top of space

// cps register layout, word offsets inside a window
`define CPSA_COUNT      18
`define CPSB_FIRST      5'd19      // layer control on the sf2 map
`define CPSB_COUNT      6
`define CPSB_ID_INDEX   5'd25
`define CPSB_ID_VALUE   16'h0401   // board id read by the game

// dip bytes, active low, all switches off
`define DIPA_VALUE      8'hFF      // 1 coin 1 credit, one slot
`define DIPB_VALUE      8'hFF      // normal difficulty
`define DIPC_VALUE      8'hFF      // game mode, no freeze, no flip

// timing
`define PHI1_SLOT       2'd1
`define PHI2_SLOT       2'd3
`define LINE_DIV_BIT    11
`define FRAME_DIV_BITS  20
`define UNMAPPED_WORD   16'hFFFF

`endif

// ==== rtl/cps_bus_pkg.sv ====
package cps_bus_pkg;

	//////////////////////////////
	// bus widths
	//////////////////////////////

	// data bus, both directions
	typedef logic [15:0] bus_word_t;

	// 68000 address, bits 23..1, no byte bit
	typedef logic [22:0] cpu_addr_t;

	// program rom word address, bits 20..1
	typedef logic [19:0] rom_addr_t;

	// work ram word address, bits 15..1
	typedef logic [14:0] ram_addr_t;

	// {upper, lower}, active high
	typedef logic [1:0] byte_en_t;

	// function code, 7 means interrupt ack
	typedef logic [2:0] fc_t;

	// word offset inside a cps window
	typedef logic [4:0] reg_index_t;

	// rom read sequencing
	typedef enum logic [1:0] {
		rom_idle, // waiting for an as_n fall
		rom_wait, // request out, no answer yet
		rom_done  // dtack low until as_n rises
	} rom_state_t;

endpackage

// ==== rtl/cpu_phase_timer.sv ====
`timescale 1ns/100ps
`include "cps_bus_config.svh"

module cpu_phase_timer (
	input  logic             clk_sys,
	input  logic             reset,
	input  cps_bus_pkg::fc_t cpu_fc,
	output logic             phi1,
	output logic             phi2,
	output logic [2:0]       ipl_n,
	output logic             vpa_n
);

	logic [1:0]                 phase_cnt;  // free running, 4 slots
	logic [`FRAME_DIV_BITS-1:0] frame_div;  // wraps once per frame
	logic                       line_bit_q; // previous line bit
	logic                       line_event;
	logic                       frame_event;
	logic                       int_ack;
	logic                       line_int;   // level 4 request
	logic                       frame_int;  // level 2 request

	assign line_event  = frame_div[`LINE_DIV_BIT] & ~line_bit_q; // rising edge
	assign frame_event = (frame_div == '0);
	assign int_ack     = (cpu_fc == 3'd7); // cpu is fetching a vector

	//////////////////////////////
	// cpu clock enables
	//////////////////////////////
	always_ff @(posedge clk_sys or posedge reset) begin
		if (reset) begin
			phase_cnt <= 2'd0;
			phi1      <= 1'b0;
			phi2      <= 1'b0;
		end else begin
			phase_cnt <= phase_cnt + 2'd1;
			phi1      <= (phase_cnt == `PHI1_SLOT);
			phi2      <= (phase_cnt == `PHI2_SLOT); // two clocks behind phi1
		end
	end

	//////////////////////////////
	// line and frame interrupts
	//////////////////////////////
	always_ff @(posedge clk_sys or posedge reset) begin
		if (reset) begin
			frame_div  <= '0;
			line_bit_q <= 1'b0;
			line_int   <= 1'b0;
			frame_int  <= 1'b0;
		end else begin
			frame_div  <= frame_div + 1'b1;
			line_bit_q <= frame_div[`LINE_DIV_BIT];
			// set beats ack in the same cycle
			if (line_event)   line_int <= 1'b1;
			else if (int_ack) line_int <= 1'b0;
			if (frame_event)  frame_int <= 1'b1;
			else if (int_ack) frame_int <= 1'b0;
		end
	end

	assign ipl_n = {~line_int, ~frame_int, 1'b1}; // ipl0 unused
	assign vpa_n = ~int_ack; // autovector on every ack

endmodule

// ==== rtl/rom_access_fsm.sv ====
`timescale 1ns/100ps

module rom_access_fsm (
	input  logic clk_sys,
	input  logic reset,
	input  logic cpu_as_n,
	input  logic cpu_rw,
	input  logic rom_sel,
	input  logic rom_ready, // memory answered, data valid now
	output logic rom_req,
	output logic dtack_n
);

	cps_bus_pkg::rom_state_t state;
	logic as_n_q;    // last cycle's strobe
	logic as_fall;
	logic rom_start;
	logic rom_read;  // cpu is inside a rom read cycle

	assign as_fall   = as_n_q & ~cpu_as_n;
	assign rom_start = as_fall & rom_sel & cpu_rw; // writes never start
	assign rom_read  = rom_sel & cpu_rw & ~cpu_as_n;

	always_ff @(posedge clk_sys or posedge reset) begin
		if (reset) begin
			state   <= cps_bus_pkg::rom_idle;
			as_n_q  <= 1'b1;
			rom_req <= 1'b0;
		end else begin
			as_n_q  <= cpu_as_n;
			rom_req <= 1'b0; // single cycle pulse
			case (state)
				cps_bus_pkg::rom_idle: begin
					if (rom_start) begin
						rom_req <= 1'b1;
						state   <= cps_bus_pkg::rom_wait;
					end
				end
				cps_bus_pkg::rom_wait: begin
					// no timeout, a slow memory stalls the cpu
					if (rom_ready) state <= cps_bus_pkg::rom_done;
				end
				cps_bus_pkg::rom_done: begin
					if (cpu_as_n) state <= cps_bus_pkg::rom_idle; // cycle ended
				end
				default: state <= cps_bus_pkg::rom_idle;
			endcase
		end
	end

	// everything outside rom acks at once
	assign dtack_n = rom_read & (state != cps_bus_pkg::rom_done);

endmodule

// ==== rtl/bus_decoder.sv ====
`timescale 1ns/100ps
`include "cps_bus_config.svh"

module bus_decoder (
	input  cps_bus_pkg::cpu_addr_t cpu_addr,
	input  logic                   cpu_rw,
	input  logic                   cpu_as_n,
	input  logic                   cpu_uds_n,
	input  logic                   cpu_lds_n,
	input  logic                   phi1,
	input  logic [15:0]            joy_1,
	input  logic [15:0]            joy_2,
	input  cps_bus_pkg::bus_word_t rom_dout,
	input  cps_bus_pkg::bus_word_t reg_rdata,
	input  cps_bus_pkg::bus_word_t ram_rdata,
	output logic                   rom_sel,
	output logic                   cpsa_sel,
	output logic                   cpsb_sel,
	output logic                   reg_wr,
	output logic                   ram_we,
	output cps_bus_pkg::byte_en_t  byte_en,
	output cps_bus_pkg::ram_addr_t ram_addr,
	output cps_bus_pkg::bus_word_t cpu_din
);

	logic [23:0] byte_addr; // lsb always zero
	logic        player_sel, serv_sel, dipa_sel, dipb_sel, dipc_sel, ram_sel;
	logic        wr_pulse;
	logic [15:0] joy_word;
	logic [7:0]  serv_byte;

	assign byte_addr = {cpu_addr, 1'b0};

	//////////////////////////////
	// chip selects
	//////////////////////////////
	assign rom_sel    = (byte_addr <= `ROM_LAST);
	assign player_sel = (byte_addr >= `PLAYER_BASE) && (byte_addr < `PLAYER_BASE + 24'h8);
	assign serv_sel   = (byte_addr == `SERV_BASE);
	assign dipa_sel   = (byte_addr == `DIPA_BASE);
	assign dipb_sel   = (byte_addr == `DIPB_BASE);
	assign dipc_sel   = (byte_addr == `DIPC_BASE);
	assign cpsa_sel   = (byte_addr >= `CPSA_BASE) && (byte_addr < `CPSB_BASE);
	assign cpsb_sel   = (byte_addr >= `CPSB_BASE) && (byte_addr < `CPSB_BASE + 24'h40);
	assign ram_sel    = (byte_addr >= `RAM_BASE); // runs to the top

	// one clock wide, lands on the phi1 inside the cycle
	assign wr_pulse = ~cpu_as_n & ~cpu_rw & phi1 & (~cpu_uds_n | ~cpu_lds_n);

	assign reg_wr   = wr_pulse & (cpsa_sel | cpsb_sel);
	assign ram_we   = wr_pulse & ram_sel; // rom has no write path
	assign byte_en  = {~cpu_uds_n, ~cpu_lds_n};
	assign ram_addr = cpu_addr[14:0];

	//////////////////////////////
	// input ports, active low
	//////////////////////////////
	assign joy_word = ~{joy_2[7:0], joy_1[7:0]}; // p2 high, p1 low

	// 0, service sw, start2, start1, 0, service, coin2, coin1
	assign serv_byte = ~{1'b0, joy_1[11], joy_2[9], joy_1[9],
		1'b0, joy_1[10], joy_2[8], joy_1[8]};

	// read mux, regions never overlap
	always_comb begin
		cpu_din = `UNMAPPED_WORD;
		if (rom_sel)
			cpu_din = rom_dout; // valid with rom_ready
		else if (ram_sel)
			cpu_din = ram_rdata;
		else if (player_sel)
			cpu_din = joy_word;
		else if (serv_sel)
			cpu_din = {serv_byte, 8'hFF}; // upper byte only
		else if (dipa_sel)
			cpu_din = {`DIPA_VALUE, 8'hFF};
		else if (dipb_sel)
			cpu_din = {`DIPB_VALUE, 8'hFF};
		else if (dipc_sel)
			cpu_din = {`DIPC_VALUE, 8'hFF};
		else if (cpsa_sel || cpsb_sel)
			cpu_din = reg_rdata; // unmapped offsets come back as FFFF
	end

endmodule

// ==== rtl/video_reg_file.sv ====
`timescale 1ns/100ps
`include "cps_bus_config.svh"

module video_reg_file (
	input  logic                   clk_sys,
	input  logic                   reset,
	input  cps_bus_pkg::cpu_addr_t cpu_addr,
	input  logic                   cpsa_sel,
	input  logic                   cpsb_sel,
	input  logic                   reg_wr,
	input  cps_bus_pkg::bus_word_t cpu_dout,
	output cps_bus_pkg::bus_word_t reg_rdata
);

	cps_bus_pkg::reg_index_t reg_idx;
	logic [2:0]              cpsb_slot; // 0..5 inside cps-b
	logic                    cpsa_hit;
	logic                    cpsb_hit;
	logic                    id_hit;
	cps_bus_pkg::bus_word_t  cpsa_regs [`CPSA_COUNT]; // obj, scroll, palette bases
	cps_bus_pkg::bus_word_t  cpsb_regs [`CPSB_COUNT]; // layer ctrl, prio masks, pal ctrl

	assign reg_idx   = cpu_addr[4:0]; // byte bits 5..1
	assign cpsb_slot = 3'(reg_idx - `CPSB_FIRST);
	assign cpsa_hit  = cpsa_sel && (reg_idx < `CPSA_COUNT);
	assign cpsb_hit  = cpsb_sel && (reg_idx >= `CPSB_FIRST)
		&& (reg_idx < `CPSB_FIRST + `CPSB_COUNT);
	assign id_hit    = cpsb_sel && (reg_idx == `CPSB_ID_INDEX);

	//////////////////////////////
	// writes, at the strobe clock
	//////////////////////////////
	always_ff @(posedge clk_sys or posedge reset) begin
		if (reset) begin
			for (int i = 0; i < `CPSA_COUNT; i++) cpsa_regs[i] <= '0;
			for (int i = 0; i < `CPSB_COUNT; i++) cpsb_regs[i] <= '0;
		end else if (reg_wr) begin
			if (cpsa_hit) cpsa_regs[reg_idx] <= cpu_dout;
			if (cpsb_hit) cpsb_regs[cpsb_slot] <= cpu_dout;
			// id word and holes drop the write
		end
	end

	// reads straight out of the array
	always_comb begin
		reg_rdata = `UNMAPPED_WORD;
		if (cpsa_hit)
			reg_rdata = cpsa_regs[reg_idx];
		else if (id_hit)
			reg_rdata = `CPSB_ID_VALUE;
		else if (cpsb_hit)
			reg_rdata = cpsb_regs[cpsb_slot];
	end

endmodule

// ==== rtl/work_ram.sv ====
`timescale 1ns/100ps

module work_ram (
	input  logic                   clk_sys,
	input  cps_bus_pkg::ram_addr_t ram_addr,
	input  logic                   ram_we,
	input  cps_bus_pkg::byte_en_t  byte_en,
	input  cps_bus_pkg::bus_word_t cpu_dout,
	output cps_bus_pkg::bus_word_t ram_rdata
);

	// 32K words, maps to block ram
	cps_bus_pkg::bus_word_t mem [1 << 15];

	always_ff @(posedge clk_sys) begin
		if (ram_we) begin
			if (byte_en[1]) mem[ram_addr][15:8] <= cpu_dout[15:8]; // uds
			if (byte_en[0]) mem[ram_addr][7:0]  <= cpu_dout[7:0];  // lds
		end
		ram_rdata <= mem[ram_addr]; // one clock behind the address
	end

endmodule

// ==== rtl/cps_bus_top.sv ====
`timescale 1ns/100ps

module cps_bus_top (
	input  logic                   clk_sys,
	input  logic                   reset,
	// cpu side
	input  cps_bus_pkg::cpu_addr_t cpu_addr,
	input  cps_bus_pkg::bus_word_t cpu_dout,
	input  logic                   cpu_as_n,
	input  logic                   cpu_rw,
	input  logic                   cpu_uds_n,
	input  logic                   cpu_lds_n,
	input  cps_bus_pkg::fc_t       cpu_fc,
	output cps_bus_pkg::bus_word_t cpu_din,
	output logic                   cpu_dtack_n,
	output logic                   cpu_vpa_n,
	output logic [2:0]             cpu_ipl_n,
	output logic                   cpu_phi1,
	output logic                   cpu_phi2,
	// controls, active high
	input  logic [15:0]            joy_1,
	input  logic [15:0]            joy_2,
	// external program memory
	input  cps_bus_pkg::bus_word_t rom_dout,
	input  logic                   rom_ready,
	output logic                   rom_req,
	output cps_bus_pkg::rom_addr_t rom_addr
);

	logic                   rom_sel;
	logic                   cpsa_sel;
	logic                   cpsb_sel;
	logic                   reg_wr;   // cps register write strobe
	logic                   ram_we;   // work ram write strobe
	cps_bus_pkg::byte_en_t  byte_en;
	cps_bus_pkg::ram_addr_t ram_addr;
	cps_bus_pkg::bus_word_t reg_rdata;
	cps_bus_pkg::bus_word_t ram_rdata;

	assign rom_addr = cpu_addr[19:0]; // byte address bits 20..1

	cpu_phase_timer u_timer (
		.clk_sys (clk_sys),
		.reset   (reset),
		.cpu_fc  (cpu_fc),
		.phi1    (cpu_phi1),
		.phi2    (cpu_phi2),
		.ipl_n   (cpu_ipl_n),
		.vpa_n   (cpu_vpa_n)
	);

	rom_access_fsm u_rom_fsm (
		.clk_sys   (clk_sys),
		.reset     (reset),
		.cpu_as_n  (cpu_as_n),
		.cpu_rw    (cpu_rw),
		.rom_sel   (rom_sel),
		.rom_ready (rom_ready),
		.rom_req   (rom_req),
		.dtack_n   (cpu_dtack_n)
	);

	bus_decoder u_decoder (
		.cpu_addr  (cpu_addr),
		.cpu_rw    (cpu_rw),
		.cpu_as_n  (cpu_as_n),
		.cpu_uds_n (cpu_uds_n),
		.cpu_lds_n (cpu_lds_n),
		.phi1      (cpu_phi1),
		.joy_1     (joy_1),
		.joy_2     (joy_2),
		.rom_dout  (rom_dout),
		.reg_rdata (reg_rdata),
		.ram_rdata (ram_rdata),
		.rom_sel   (rom_sel),
		.cpsa_sel  (cpsa_sel),
		.cpsb_sel  (cpsb_sel),
		.reg_wr    (reg_wr),
		.ram_we    (ram_we),
		.byte_en   (byte_en),
		.ram_addr  (ram_addr),
		.cpu_din   (cpu_din)
	);

	video_reg_file u_regs (
		.clk_sys   (clk_sys),
		.reset     (reset),
		.cpu_addr  (cpu_addr),
		.cpsa_sel  (cpsa_sel),
		.cpsb_sel  (cpsb_sel),
		.reg_wr    (reg_wr),
		.cpu_dout  (cpu_dout),
		.reg_rdata (reg_rdata)
	);

	work_ram u_ram (
		.clk_sys   (clk_sys),
		.ram_addr  (ram_addr),
		.ram_we    (ram_we),
		.byte_en   (byte_en),
		.cpu_dout  (cpu_dout),
		.ram_rdata (ram_rdata)
	);

endmodule

// ==== testbench/tb_cps_bus.sv ====
`timescale 1ns/100ps
`include "cps_bus_config.svh"

module tb_cps_bus;

	typedef enum logic [1:0] {k_write, k_read, k_rom, k_ack} kind_t;

	typedef struct packed {
		kind_t       kind;
		logic [23:0] addr; // byte address
		logic [15:0] data;
		logic [1:0]  be;   // {upper, lower}
		logic [15:0] want; // read word, or ipl_n after an ack
	} entry_t;

	logic                   clk_sys;
	logic                   reset;
	cps_bus_pkg::cpu_addr_t cpu_addr;
	cps_bus_pkg::bus_word_t cpu_dout;
	logic                   cpu_as_n;
	logic                   cpu_rw;
	logic                   cpu_uds_n;
	logic                   cpu_lds_n;
	cps_bus_pkg::fc_t       cpu_fc;
	cps_bus_pkg::bus_word_t cpu_din;
	logic                   cpu_dtack_n;
	logic                   cpu_vpa_n;
	logic [2:0]             cpu_ipl_n;
	logic                   cpu_phi1;
	logic                   cpu_phi2;
	logic [15:0]            joy_1;
	logic [15:0]            joy_2;
	cps_bus_pkg::bus_word_t rom_dout;
	logic                   rom_ready;
	logic                   rom_req;
	cps_bus_pkg::rom_addr_t rom_addr;

	entry_t      table_q[$];
	logic        table_ready = 1'b0;
	logic [23:0] cur_addr;          // cycle in flight
	logic        ready_seen = 1'b0; // rom_ready sampled in this cycle
	int          req_count = 0;     // rom_req pulses so far
	int          cyc = 0;           // clocks since reset release

	cps_bus_top UUT (.*);

	always #20 clk_sys = ~clk_sys;

	always @(posedge clk_sys)
		if (!reset) cyc <= cyc + 1;

	task automatic stop_run(input string why);
		$display("%s", why);
		$display("Checks failed");
		$fatal(1, "run stopped");
	endtask

	task automatic report_mismatch(input string name, input logic [31:0] got,
		input logic [31:0] want);
		$display("[ERROR] %s = %h, expected %h", name, got, want);
		$display("Checks failed");
		$fatal(1, "value mismatch");
	endtask

	function automatic logic [31:0] next_random(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	// every address bit lands in the word
	function automatic logic [15:0] rom_word(input logic [19:0] ra);
		return ra[15:0] ^ {4{ra[19:16]}} ^ 16'h9C3A;
	endfunction

	function automatic logic [15:0] reg_pattern(input int i, input logic [15:0] seed);
		return seed ^ 16'(i * 259); // distinct per offset
	endfunction

	function automatic void add_entry(input kind_t k, input logic [23:0] a,
		input logic [15:0] d, input logic [1:0] be, input logic [15:0] w);
		entry_t e;
		e.kind = k;
		e.addr = a;
		e.data = d;
		e.be   = be;
		e.want = w;
		table_q.push_back(e);
	endfunction

	//////////////////////////////
	// stimulus table
	//////////////////////////////
	function automatic void build_table();
		int          i;
		logic [23:0] b_addr;
		add_entry(k_ack, 24'h0, 16'h0, 2'b00, 16'h0007); // frame int cleared
		for (i = 0; i < `CPSA_COUNT; i++)
			add_entry(k_write, `CPSA_BASE + 24'(2 * i), reg_pattern(i, 16'hA5C0), 2'b11, 16'h0);
		for (i = 0; i < `CPSB_COUNT; i++) begin
			b_addr = `CPSB_BASE + 24'(2 * (int'(`CPSB_FIRST) + i));
			add_entry(k_write, b_addr, reg_pattern(i, 16'h3C90), 2'b11, 16'h0);
		end
		add_entry(k_write, `CPSB_BASE + 24'(2 * int'(`CPSB_ID_INDEX)), 16'h1234, 2'b11, 16'h0);
		add_entry(k_write, `CPSB_BASE, 16'h5555, 2'b11, 16'h0); // hole at offset 0
		for (i = 0; i < `CPSA_COUNT; i++)
			add_entry(k_read, `CPSA_BASE + 24'(2 * i), 16'h0, 2'b11, reg_pattern(i, 16'hA5C0));
		for (i = 0; i < `CPSB_COUNT; i++) begin
			b_addr = `CPSB_BASE + 24'(2 * (int'(`CPSB_FIRST) + i));
			add_entry(k_read, b_addr, 16'h0, 2'b11, reg_pattern(i, 16'h3C90));
		end
		add_entry(k_read, `CPSB_BASE + 24'(2 * int'(`CPSB_ID_INDEX)), 16'h0, 2'b11, 16'h0401);
		add_entry(k_read, `CPSB_BASE, 16'h0, 2'b11, 16'hFFFF);
		add_entry(k_read, `CPSA_BASE + 24'd40, 16'h0, 2'b11, 16'hFFFF); // cps-a offset 20
		// work ram, byte lanes merge into the old word
		add_entry(k_write, 24'hFF0000, 16'h1234, 2'b11, 16'h0);
		add_entry(k_write, 24'hFF1236, 16'h5566, 2'b11, 16'h0);
		add_entry(k_write, 24'hFF1236, 16'hAB00, 2'b10, 16'h0);
		add_entry(k_write, 24'hFF8ACE, 16'h7788, 2'b11, 16'h0);
		add_entry(k_write, 24'hFF8ACE, 16'h00CD, 2'b01, 16'h0);
		add_entry(k_write, 24'hFFFFFE, 16'hC3E1, 2'b11, 16'h0);
		add_entry(k_read, 24'hFF1236, 16'h0, 2'b11, 16'hAB66);
		add_entry(k_read, 24'hFF8ACE, 16'h0, 2'b11, 16'h77CD);
		add_entry(k_read, 24'hFFFFFE, 16'h0, 2'b11, 16'hC3E1);
		add_entry(k_read, 24'hFF0000, 16'h0, 2'b11, 16'h1234);
		// program rom, word address is byte bits 20..1
		add_entry(k_rom, 24'h000000, 16'h0, 2'b11, rom_word(20'h00000));
		add_entry(k_rom, 24'h012344, 16'h0, 2'b11, rom_word(20'h091A2));
		add_entry(k_write, 24'h000100, 16'hDEAD, 2'b11, 16'h0); // no request expected
		add_entry(k_rom, 24'h1FFFFE, 16'h0, 2'b11, rom_word(20'hFFFFF));
		add_entry(k_rom, 24'h2ABCDE, 16'h0, 2'b11, rom_word(20'h55E6F));
		add_entry(k_rom, 24'h3FFFFE, 16'h0, 2'b11, rom_word(20'hFFFFF));
		// input ports, active low on the bus
		add_entry(k_read, `PLAYER_BASE, 16'h0, 2'b11, 16'h35CA); // p2 CA, p1 35 inverted
		add_entry(k_read, `PLAYER_BASE + 24'h6, 16'h0, 2'b11, 16'h35CA);
		add_entry(k_read, `SERV_BASE, 16'h0, 2'b11, 16'h8EFF); // sw, both starts, coin1
		add_entry(k_read, `DIPA_BASE, 16'h0, 2'b11, {`DIPA_VALUE, 8'hFF});
		add_entry(k_read, `DIPB_BASE, 16'h0, 2'b11, {`DIPB_VALUE, 8'hFF});
		add_entry(k_read, `DIPC_BASE, 16'h0, 2'b11, {`DIPC_VALUE, 8'hFF});
		add_entry(k_read, 24'h400000, 16'h0, 2'b11, `UNMAPPED_WORD); // gap above rom
		add_entry(k_read, 24'h900000, 16'h0, 2'b11, `UNMAPPED_WORD);
	endfunction

	//////////////////////////////
	// bus cycles
	//////////////////////////////
	task automatic run_bus_cycle(input entry_t e);
		int reqs_before;
		reqs_before = req_count;
		cur_addr    = e.addr;
		ready_seen  = 1'b0;
		@(posedge clk_sys);
		cpu_addr  <= e.addr[23:1];
		cpu_dout  <= e.data;
		cpu_rw    <= (e.kind != k_write);
		cpu_uds_n <= ~e.be[1];
		cpu_lds_n <= ~e.be[0];
		cpu_as_n  <= 1'b0;
		do @(negedge clk_sys); while (cpu_dtack_n !== 1'b0);
		if (e.kind == k_rom)
			assert (ready_seen) else stop_run("cpu_dtack_n fell before rom_ready");
		repeat (4) @(negedge clk_sys); // covers a phi1 and the ram latency
		assert (cpu_vpa_n === 1'b1) else report_mismatch("cpu_vpa_n", cpu_vpa_n, 1);
		if (e.kind != k_write)
			assert (cpu_din === e.want) else report_mismatch("cpu_din", cpu_din, e.want);
		assert (req_count == reqs_before + ((e.kind == k_rom) ? 1 : 0))
			else report_mismatch("rom_req count", req_count - reqs_before, e.kind == k_rom);
		@(posedge clk_sys);
		cpu_as_n  <= 1'b1;
		cpu_uds_n <= 1'b1;
		cpu_lds_n <= 1'b1;
		cpu_rw    <= 1'b1;
	endtask

	task automatic run_ack(input logic [2:0] want_ipl);
		@(posedge clk_sys);
		cpu_fc <= 3'd7; // vector fetch
		@(negedge clk_sys);
		assert (cpu_vpa_n === 1'b0) else report_mismatch("cpu_vpa_n", cpu_vpa_n, 0);
		@(posedge clk_sys);
		cpu_fc <= 3'd5;
		@(negedge clk_sys);
		assert (cpu_vpa_n === 1'b1) else report_mismatch("cpu_vpa_n", cpu_vpa_n, 1);
		assert (cpu_ipl_n === want_ipl) else report_mismatch("cpu_ipl_n", cpu_ipl_n, want_ipl);
	endtask

	task automatic check_phases();
		int last1;
		int n1;
		int n2;
		last1 = -1;
		n1    = 0;
		n2    = 0;
		for (int i = 0; i < 16; i++) begin
			@(negedge clk_sys);
			if (cpu_phi1) begin
				if (last1 >= 0)
					assert (i - last1 == 4) else stop_run("phi1 does not repeat every 4 clocks");
				last1 = i;
				n1++;
			end
			if (cpu_phi2) begin
				if (last1 >= 0)
					assert (i - last1 == 2) else stop_run("phi2 is not two clocks after phi1");
				n2++;
			end
		end
		assert (n1 == 4 && n2 == 4) else stop_run("phase enables missed a pulse");
	endtask

	// answers each request after 1 to 8 clocks
	initial begin : rom_responder
		logic [31:0] rng;
		int          wait_n;
		rng       = 32'hf2d6;
		rom_dout  = 16'h0;
		rom_ready = 1'b0;
		forever begin
			@(negedge clk_sys);
			if (rom_req === 1'b1) begin
				assert (rom_addr === cur_addr[20:1])
					else report_mismatch("rom_addr", rom_addr, cur_addr[20:1]);
				req_count  = req_count + 1;
				rng        = next_random(rng);
				wait_n     = int'(rng % 8) + 1;
				repeat (wait_n) @(posedge clk_sys);
				rom_dout   <= rom_word(rom_addr);
				rom_ready  <= 1'b1;
				@(posedge clk_sys);
				rom_ready  <= 1'b0;
				ready_seen = 1'b1; // fsm samples rom_ready on this edge
			end
		end
	end

	initial begin : watchdog
		wait (table_ready);
		repeat (table_q.size() * 20 + 4096) @(posedge clk_sys);
		stop_run("watchdog expired before the tests finished");
	end

	initial begin : main
		int line_cyc;
		clk_sys   = 1'b0;
		reset     = 1'b1;
		cpu_addr  = '0;
		cpu_dout  = '0;
		cpu_as_n  = 1'b1;
		cpu_rw    = 1'b1;
		cpu_uds_n = 1'b1;
		cpu_lds_n = 1'b1;
		cpu_fc    = 3'd5;     // supervisor data
		joy_1     = 16'h0B35; // service sw, start1, coin1 pressed
		joy_2     = 16'h02CA; // start2 pressed
		cur_addr  = '0;
		line_cyc  = (1 << `LINE_DIV_BIT) + 1;
		build_table();
		table_ready = 1'b1;
		repeat (3) @(posedge clk_sys);
		reset <= 1'b0;
		repeat (2) @(negedge clk_sys); // first clock after release
		assert (rom_req === 1'b0) else report_mismatch("rom_req", rom_req, 0);
		assert (cpu_dtack_n === 1'b0) else report_mismatch("cpu_dtack_n", cpu_dtack_n, 0);
		assert (cpu_ipl_n === 3'b101) else report_mismatch("cpu_ipl_n", cpu_ipl_n, 3'b101);
		check_phases();
		foreach (table_q[i]) begin
			if (table_q[i].kind == k_ack)
				run_ack(table_q[i].want[2:0]);
			else
				run_bus_cycle(table_q[i]);
		end
		// line interrupt, one clock after divider bit 11 rises
		assert (cyc < line_cyc - 1) else stop_run("table ran past the first line interrupt");
		while (cyc < line_cyc - 1) @(negedge clk_sys);
		assert (cpu_ipl_n[2] === 1'b1) else report_mismatch("cpu_ipl_n[2]", cpu_ipl_n[2], 1);
		@(negedge clk_sys);
		assert (cpu_ipl_n === 3'b011) else report_mismatch("cpu_ipl_n", cpu_ipl_n, 3'b011);
		run_ack(3'b111);
		$display("All checks passed");
		$finish;
	end

endmodule

// ==== sources.f ====
+incdir+rtl
rtl/cps_bus_pkg.sv
rtl/cpu_phase_timer.sv
rtl/rom_access_fsm.sv
rtl/bus_decoder.sv
rtl/video_reg_file.sv
rtl/work_ram.sv
rtl/cps_bus_top.sv
testbench/tb_cps_bus.sv

// ==== Makefile ====
.PHONY: run clean

run: obj_dir/Vtb_cps_bus
	./obj_dir/Vtb_cps_bus

obj_dir/Vtb_cps_bus: sources.f rtl/cps_bus_config.svh $(shell grep -v '^+' sources.f)
	verilator --binary --timing --assert -Wno-fatal --top-module tb_cps_bus \
		-f sources.f -o Vtb_cps_bus

clean:
	rm -rf obj_dir
